// ==== build.f ====
common/projector_pkg.sv
common/scan_point_if.sv
verilog/point_rate_timer.sv
projector/scan_pattern_gen.sv
projector/dac_scan_writer.sv
verilog/projector_top.sv
dv/projector_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the projector testbench with Verilator and runs it into a log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/projector_sim

verilator --binary --timing --assert -f build.f --top-module projector_tb \
	-Mdir obj_dir -o projector_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./${BIN}" > "${LOG}" 2>&1
sim_status=$?
cat "${LOG}"
if [ ${sim_status} -ne 0 ]; then
	echo "Simulation exited with status ${sim_status}"
	exit 1
fi

if grep -qx "Test completed successfully" "${LOG}"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see ${LOG}"
	exit 1
fi

// ==== dv/projector_tb.sv ====
`timescale 1ns/1ps

module projector_tb;
	import projector_pkg::*;

	localparam int TICK_BASE  = 128;
	localparam int SCAN_STEP  = 64;
	localparam int CLK_HALF   = 5;
	// 4 tests x 10 points x 1024 cycles x 1.5, rounded up
	localparam int MAX_CYCLES = 64000;

	typedef struct packed
	{
		logic [POINT_W-1:0] x;
		logic [POINT_W-1:0] y;
		logic [RGB_W-1:0]   rgb;
	} point_t;

	logic               USER_CLK = 1'b0;
	logic               rst_n;
	logic [1:0]         mode_control;
	logic [1:0]         update_rate;
	logic               laser_enable;
	logic               dac_sclk;
	logic               dac_mosi;
	logic               dac_csn;
	logic               dac_latch;
	logic [RGB_W-1:0]   laser_rgb;

	// Decoder state
	logic [DAC_WORD_W-1:0] shift_word = '0;
	logic [DAC_WORD_W-1:0] x_word = '0;
	logic [DAC_WORD_W-1:0] y_word = '0;
	logic                  word_sel = 1'b0;
	int                    bit_cnt = 0;
	int                    words_seen = 0;

	// Compare state
	scan_mode_e cmp_mode;
	scan_mode_e prev_mode = MODE_BLANK;
	point_t     exp_pt;
	int         pt_n = 0;
	int         latch_cnt = 0;
	int         cmp_errors = 0;

	// Sequencer state
	string  test_name = "reset";
	integer seed;
	int     cyc_cnt = 0;
	int     latch_cyc;
	int     rel_cyc;
	int     main_errors = 0;
	int     start_errs;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     order [4];
	int     i;
	int     j;
	int     tmp;
	int     t_a;

	projector_top #(
		.TICK_BASE    (TICK_BASE),
		.SCAN_STEP    (SCAN_STEP)
	) i_projector_top (
		.USER_CLK     (USER_CLK),
		.rst_n        (rst_n),
		.mode_control (mode_control),
		.update_rate  (update_rate),
		.laser_enable (laser_enable),
		.dac_sclk     (dac_sclk),
		.dac_mosi     (dac_mosi),
		.dac_csn      (dac_csn),
		.dac_latch    (dac_latch),
		.laser_rgb    (laser_rgb)
	);

	always
	begin
		#CLK_HALF USER_CLK = ~USER_CLK;
	end

	// Run limit, also the cycle base for spacing checks
	always @(posedge USER_CLK)
	begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt >= MAX_CYCLES)
		begin
			$display("timeout: run stopped after %0d cycles, tests did not finish", cyc_cnt);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model of one scan point
	////////////////////////////////////////////////////////////////////////////
	function automatic point_t expected_point(input scan_mode_e mode, input int n,
		input logic en);
		point_t p;
		logic [POINT_W-1:0] ramp;
		ramp = POINT_W'((n * SCAN_STEP) % 4096);
		p.x   = MID_POS;
		p.y   = MID_POS;
		p.rgb = 3'b000;
		case (mode)
			MODE_SQUARE:
			begin
				// Corner walk LL, LR, UR, UL
				case (n % 4)
					0: begin p.x = CORNER_LO; p.y = CORNER_LO; end
					1: begin p.x = CORNER_HI; p.y = CORNER_LO; end
					2: begin p.x = CORNER_HI; p.y = CORNER_HI; end
					default: begin p.x = CORNER_LO; p.y = CORNER_HI; end
				endcase
				p.rgb = 3'b100;
			end
			MODE_SWEEP:
			begin
				p.x   = ramp;
				p.rgb = 3'b010;
			end
			MODE_DIAG:
			begin
				p.x   = ramp;
				p.y   = ramp;
				p.rgb = 3'b001;
			end
			default:
			begin
				p.rgb = 3'b000;
			end
		endcase
		if (!en)
		begin
			p.rgb = 3'b000;
		end
		return p;
	endfunction

	// SPI decoder, first word of a frame is X
	always @(posedge dac_sclk)
	begin
		if (dac_csn === 1'b0)
		begin
			shift_word = {shift_word[DAC_WORD_W-2:0], dac_mosi};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == DAC_WORD_W)
			begin
				if (word_sel == 1'b0)
					x_word = shift_word;
				else
					y_word = shift_word;
				word_sel = ~word_sel;
				words_seen = words_seen + 1;
				bit_cnt = 0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare at every latch pulse
	////////////////////////////////////////////////////////////////////////////
	always @(posedge USER_CLK)
	begin
		if (dac_latch === 1'b1)
		begin
			cmp_mode = scan_mode_e'(mode_control);
			// Index restarts on a mode change
			if (cmp_mode != prev_mode)
				pt_n = 0;
			exp_pt = expected_point(cmp_mode, pt_n, laser_enable);
			latch_cnt = latch_cnt + 1;
			if (words_seen != 2 * latch_cnt)
			begin
				$display("error %s: %0d DAC words decoded by latch %0d, two per frame expected",
					test_name, words_seen, latch_cnt);
				cmp_errors = cmp_errors + 1;
			end
			// Channel bit 0 for X, 1 for Y
			if (x_word[15:12] != {1'b0, DAC_CFG})
			begin
				$display("error %s: X word header expected %h actual %h", test_name,
					{1'b0, DAC_CFG}, x_word[15:12]);
				cmp_errors = cmp_errors + 1;
			end
			if (y_word[15:12] != {1'b1, DAC_CFG})
			begin
				$display("error %s: Y word header expected %h actual %h", test_name,
					{1'b1, DAC_CFG}, y_word[15:12]);
				cmp_errors = cmp_errors + 1;
			end
			if (x_word[11:0] != exp_pt.x)
			begin
				$display("error %s: X of point %0d expected %h actual %h", test_name, pt_n,
					exp_pt.x, x_word[11:0]);
				cmp_errors = cmp_errors + 1;
			end
			if (y_word[11:0] != exp_pt.y)
			begin
				$display("error %s: Y of point %0d expected %h actual %h", test_name, pt_n,
					exp_pt.y, y_word[11:0]);
				cmp_errors = cmp_errors + 1;
			end
			if (laser_rgb !== exp_pt.rgb)
			begin
				$display("error %s: colour of point %0d expected %b actual %b", test_name,
					pt_n, exp_pt.rgb, laser_rgb);
				cmp_errors = cmp_errors + 1;
			end
			prev_mode = cmp_mode;
			pt_n = pt_n + 1;
		end
	end

	// Next latch pulse, returns 1 ns after its edge
	task automatic wait_latch();
		@(posedge USER_CLK);
		while (dac_latch !== 1'b1)
		begin
			@(posedge USER_CLK);
		end
		#1;
		latch_cyc = cyc_cnt;
	endtask

	task automatic run_points(input int count);
		repeat (count) wait_latch();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		start_errs = cmp_errors + main_errors;
	endtask

	task automatic finish_test();
		int errs;
		errs = cmp_errors + main_errors - start_errs;
		tests_run = tests_run + 1;
		if (errs != 0)
			tests_failed = tests_failed + 1;
		$display("test %-12s %s, %0d errors", test_name, (errs == 0) ? "passed" : "FAILED", errs);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence, switches change right after a latch
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		seed = 32'h84e1_f2f2;
		rst_n = 1'b0;
		mode_control = MODE_BLANK;
		update_rate = 2'd0;
		laser_enable = 1'b1;
		repeat (5) @(posedge USER_CLK);
		#1 rst_n = 1'b1;
		rel_cyc = cyc_cnt;

		// Idle outputs after reset, first latch one period later at the earliest
		start_test("reset");
		if (dac_csn !== 1'b1 || dac_latch !== 1'b0 || laser_rgb !== 3'b000)
		begin
			$display("error reset: csn/latch/rgb expected 1/0/000 actual %b/%b/%b",
				dac_csn, dac_latch, laser_rgb);
			main_errors = main_errors + 1;
		end
		wait_latch();
		if (latch_cyc - rel_cyc < TICK_BASE)
		begin
			$display("reset: first latch pulse came %0d cycles after reset, before one tick period",
				latch_cyc - rel_cyc);
			main_errors = main_errors + 1;
		end
		finish_test();

		start_test("mode_blank");
		mode_control = MODE_BLANK;
		run_points(10);
		finish_test();

		start_test("mode_square");
		mode_control = MODE_SQUARE;
		run_points(10);
		finish_test();

		// Long enough for the ramp to pass 4096 and wrap
		start_test("mode_sweep");
		mode_control = MODE_SWEEP;
		run_points(70);
		finish_test();

		start_test("mode_diag");
		mode_control = MODE_DIAG;
		run_points(10);
		finish_test();

		// Rates in shuffled order
		start_test("tick_rate");
		for (i = 0; i < 4; i++)
			order[i] = i;
		for (i = 3; i > 0; i--)
		begin
			j = $unsigned($random(seed)) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (i = 0; i < 4; i++)
		begin
			update_rate = 2'(order[i]);
			// New rate takes hold at the next tick
			wait_latch();
			t_a = latch_cyc;
			wait_latch();
			if (latch_cyc - t_a != (TICK_BASE << order[i]))
			begin
				$display("error tick_rate: spacing at rate %0d expected %0d actual %0d",
					order[i], TICK_BASE << order[i], latch_cyc - t_a);
				main_errors = main_errors + 1;
			end
		end
		finish_test();

		start_test("laser_off");
		update_rate = 2'd0;
		mode_control = MODE_DIAG;
		laser_enable = 1'b0;
		run_points(10);
		finish_test();

		$display("tests %0d, passed %0d, failed %0d, points %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, latch_cnt, cmp_errors + main_errors);
		if (tests_failed == 0 && cmp_errors + main_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verilog/projector_top.sv ====
`timescale 1ns/1ps

module projector_top #(
	parameter int TICK_BASE = 128,
	parameter int SCAN_STEP = 64
) (
	input  logic                            USER_CLK,
	input  logic                            rst_n,
	input  logic [1:0]                      mode_control,
	input  logic [1:0]                      update_rate,
	input  logic                            laser_enable,
	output logic                            dac_sclk,
	output logic                            dac_mosi,
	output logic                            dac_csn,
	output logic                            dac_latch,
	output logic [projector_pkg::RGB_W-1:0] laser_rgb
);
	import projector_pkg::*;

	// Tick and registered mode from the switch side
	logic       tick;
	scan_mode_e mode;

	// One point per tick from generator to DAC writer
	scan_point_if pt_if ();

	////////////////////////////////////////////////////////////////////////////
	// Switch side, point generation, DAC output
	////////////////////////////////////////////////////////////////////////////
	point_rate_timer #(
		.TICK_BASE    (TICK_BASE)
	) i_point_rate_timer (
		.USER_CLK     (USER_CLK),
		.rst_n        (rst_n),
		.update_rate  (update_rate),
		.mode_control (mode_control),
		.tick         (tick),
		.mode         (mode)
	);

	scan_pattern_gen #(
		.SCAN_STEP    (SCAN_STEP)
	) i_scan_pattern_gen (
		.USER_CLK     (USER_CLK),
		.rst_n        (rst_n),
		.tick         (tick),
		.mode         (mode),
		.laser_enable (laser_enable),
		.pt           (pt_if.pattern_gen)
	);

	dac_scan_writer i_dac_scan_writer (
		.USER_CLK     (USER_CLK),
		.rst_n        (rst_n),
		.pt           (pt_if.writer),
		.dac_sclk     (dac_sclk),
		.dac_mosi     (dac_mosi),
		.dac_csn      (dac_csn),
		.dac_latch    (dac_latch),
		.laser_rgb    (laser_rgb)
	);

endmodule

// ==== projector/dac_scan_writer.sv ====
`timescale 1ns/1ps

module dac_scan_writer (
	input  logic                            USER_CLK,
	input  logic                            rst_n,
	scan_point_if.writer                    pt,
	output logic                            dac_sclk,
	output logic                            dac_mosi,
	output logic                            dac_csn,
	output logic                            dac_latch,
	output logic [projector_pkg::RGB_W-1:0] laser_rgb
);
	import projector_pkg::*;

	// Two USER_CLK cycles per DAC bit
	localparam int WORD_CYC = 2 * DAC_WORD_W;
	localparam int CYC_W    = $clog2(WORD_CYC);

	typedef enum logic [2:0]
	{
		IDLE,
		SHIFT_X,
		GAP,
		SHIFT_Y,
		LATCH
	} wr_state_e;

	wr_state_e             state_q;
	logic [CYC_W-1:0]      cnt_q;
	logic                  sclk_q;
	logic                  csn_q;
	logic                  latch_q;
	logic                  busy_q;
	logic [RGB_W-1:0]      rgb_out_q;
	logic [DAC_WORD_W-1:0] shreg_q;
	logic [POINT_W-1:0]    y_data_q;
	logic [RGB_W-1:0]      rgb_cap_q;
	logic                  shifting;
	logic                  word_done;
	logic                  start;

	assign start     = (state_q == IDLE) & pt.point_strobe;
	assign shifting  = (state_q == SHIFT_X) | (state_q == SHIFT_Y);
	assign word_done = shifting & (cnt_q == CYC_W'(WORD_CYC - 1));

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM: X word, 2-cycle gap, Y word, latch
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge USER_CLK)
	begin
		if (!rst_n)
		begin
			state_q   <= IDLE;
			cnt_q     <= '0;
			sclk_q    <= 1'b0;
			csn_q     <= 1'b1;
			latch_q   <= 1'b0;
			busy_q    <= 1'b0;
			rgb_out_q <= '0;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (pt.point_strobe)
					begin
						// Select the DAC, first bit already on mosi
						csn_q   <= 1'b0;
						busy_q  <= 1'b1;
						cnt_q   <= '0;
						state_q <= SHIFT_X;
					end
				end
				SHIFT_X, SHIFT_Y:
				begin
					// Odd counts have sclk high
					sclk_q <= ~sclk_q;
					cnt_q  <= cnt_q + 1'b1;
					if (word_done)
					begin
						csn_q   <= 1'b1;
						cnt_q   <= '0;
						state_q <= (state_q == SHIFT_X) ? GAP : LATCH;
					end
				end
				GAP:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == CYC_W'(1))
					begin
						csn_q   <= 1'b0;
						cnt_q   <= '0;
						state_q <= SHIFT_Y;
					end
				end
				LATCH:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == '0)
					begin
						// Colour and position switch together
						latch_q   <= 1'b1;
						rgb_out_q <= rgb_cap_q;
					end
					else
					begin
						latch_q <= 1'b0;
						busy_q  <= 1'b0;
						cnt_q   <= '0;
						state_q <= IDLE;
					end
				end
				default:
				begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// Shift register and captured point
	always_ff @(posedge USER_CLK)
	begin
		if (start)
		begin
			shreg_q   <= {CH_X, DAC_CFG, pt.point_x};
			y_data_q  <= pt.point_y;
			rgb_cap_q <= pt.point_rgb;
		end
		else if (word_done && state_q == SHIFT_X)
		begin
			// Y word ready before csn drops again
			shreg_q <= {CH_Y, DAC_CFG, y_data_q};
		end
		else if (shifting && sclk_q)
		begin
			// Next bit on the falling edge
			shreg_q <= {shreg_q[DAC_WORD_W-2:0], 1'b0};
		end
	end

	assign dac_sclk  = sclk_q;
	assign dac_mosi  = shreg_q[DAC_WORD_W-1] & ~csn_q;
	assign dac_csn   = csn_q;
	assign dac_latch = latch_q;
	assign laser_rgb = rgb_out_q;
	assign pt.busy   = busy_q;

	// Clock edges only inside a selected word
	a_sclk_in_csn: assert property (
		@(posedge USER_CLK) disable iff (!rst_n)
		$changed(dac_sclk) |-> !$past(dac_csn)
	);

	// Latch only with the DAC deselected
	a_latch_csn_high: assert property (
		@(posedge USER_CLK) disable iff (!rst_n)
		dac_latch |-> dac_csn
	);

endmodule

// ==== projector/scan_pattern_gen.sv ====
`timescale 1ns/1ps

module scan_pattern_gen #(
	parameter int SCAN_STEP = 64
) (
	input  logic                      USER_CLK,
	input  logic                      rst_n,
	input  logic                      tick,
	input  projector_pkg::scan_mode_e mode,
	input  logic                      laser_enable,
	scan_point_if.pattern_gen         pt
);
	import projector_pkg::*;

	logic [POINT_W-1:0] idx_q;
	scan_mode_e         last_mode_q;
	logic [POINT_W-1:0] idx_eff;
	logic [POINT_W-1:0] sweep_pos;
	logic [POINT_W-1:0] next_x;
	logic [POINT_W-1:0] next_y;
	logic [RGB_W-1:0]   next_rgb;
	logic               issue;

	// Tick dropped while the writer is still busy
	assign issue = tick & ~pt.busy;

	// Index restarts on any mode change
	assign idx_eff = (mode != last_mode_q) ? '0 : idx_q;

	// Ramp position, wraps modulo 4096
	assign sweep_pos = POINT_W'(idx_eff * SCAN_STEP);

	////////////////////////////////////////////////////////////////////////////
	// Point lookup per mode
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		next_x   = MID_POS;
		next_y   = MID_POS;
		next_rgb = RGB_OFF;
		case (mode)
			MODE_SQUARE:
			begin
				// Corners in order LL, LR, UR, UL
				next_x   = (idx_eff[1:0] == 2'd1 || idx_eff[1:0] == 2'd2) ? CORNER_HI : CORNER_LO;
				next_y   = idx_eff[1] ? CORNER_HI : CORNER_LO;
				next_rgb = RGB_RED;
			end
			MODE_SWEEP:
			begin
				// Horizontal line through the centre
				next_x   = sweep_pos;
				next_rgb = RGB_GREEN;
			end
			MODE_DIAG:
			begin
				next_x   = sweep_pos;
				next_y   = sweep_pos;
				next_rgb = RGB_BLUE;
			end
			default:
			begin
				// Blank, centred and dark
				next_rgb = RGB_OFF;
			end
		endcase
		// Interlock turns the diodes off but keeps the scan going
		if (!laser_enable)
		begin
			next_rgb = RGB_OFF;
		end
	end

	// Control state
	always_ff @(posedge USER_CLK)
	begin
		if (!rst_n)
		begin
			idx_q           <= '0;
			last_mode_q     <= MODE_BLANK;
			pt.point_strobe <= 1'b0;
		end
		else
		begin
			pt.point_strobe <= issue;
			if (issue)
			begin
				idx_q       <= idx_eff + 1'b1;
				last_mode_q <= mode;
			end
		end
	end

	// Payload, held until the next issued point
	always_ff @(posedge USER_CLK)
	begin
		if (issue)
		begin
			pt.point_x   <= next_x;
			pt.point_y   <= next_y;
			pt.point_rgb <= next_rgb;
		end
	end

	// Writer must have dropped busy before any new point
	a_no_strobe_when_busy: assert property (
		@(posedge USER_CLK) disable iff (!rst_n)
		pt.point_strobe |-> !pt.busy
	);

endmodule

// ==== verilog/point_rate_timer.sv ====
`timescale 1ns/1ps

module point_rate_timer #(
	parameter int TICK_BASE = 128
) (
	input  logic                    USER_CLK,
	input  logic                    rst_n,
	input  logic [1:0]              update_rate,
	input  logic [1:0]              mode_control,
	output logic                    tick,
	output projector_pkg::scan_mode_e mode
);
	import projector_pkg::*;

	// Room for the longest period, base shifted by 3
	localparam int CNT_W = $clog2(TICK_BASE * 8) + 1;

	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] period_last;
	logic [1:0]       rate_q;
	scan_mode_e       mode_q;

	// Last count of the current period
	assign period_last = (CNT_W'(TICK_BASE) << rate_q) - 1'b1;

	always_ff @(posedge USER_CLK)
	begin
		if (!rst_n)
		begin
			cnt_q  <= '0;
			tick   <= 1'b0;
			// Switches sampled during reset so the first period has the right length
			rate_q <= update_rate;
			mode_q <= scan_mode_e'(mode_control);
		end
		else if (cnt_q == period_last)
		begin
			cnt_q  <= '0;
			tick   <= 1'b1;
			// New switch settings apply from this boundary on
			rate_q <= update_rate;
			mode_q <= scan_mode_e'(mode_control);
		end
		else
		begin
			cnt_q <= cnt_q + 1'b1;
			tick  <= 1'b0;
		end
	end

	// Mode stays constant over a whole period
	assign mode = mode_q;

endmodule

// ==== common/scan_point_if.sv ====
`timescale 1ns/1ps

interface scan_point_if;
	import projector_pkg::*;

	// Point payload, valid in the strobe cycle only
	logic [POINT_W-1:0] point_x;
	logic [POINT_W-1:0] point_y;
	logic [RGB_W-1:0]   point_rgb;
	logic               point_strobe;
	// High from the cycle after capture until the frame is latched
	logic               busy;

	// Generator side issues points
	modport pattern_gen
	(
		output point_x, point_y, point_rgb, point_strobe,
		input  busy
	);

	// DAC writer side consumes them
	modport writer
	(
		input  point_x, point_y, point_rgb, point_strobe,
		output busy
	);

endinterface

// ==== common/projector_pkg.sv ====
package projector_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Scan modes, in DIP switch order
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0]
	{
		MODE_BLANK  = 2'd0,
		MODE_SQUARE = 2'd1,
		MODE_SWEEP  = 2'd2,
		MODE_DIAG   = 2'd3
	} scan_mode_e;

	// Galvo coordinate and laser colour widths
	localparam int POINT_W = 12;
	localparam int RGB_W   = 3;

	// Fixed positions on the 12-bit galvo range
	localparam logic [POINT_W-1:0] MID_POS   = 12'd2048;
	localparam logic [POINT_W-1:0] CORNER_LO = 12'd1024;
	localparam logic [POINT_W-1:0] CORNER_HI = 12'd3072;

	// Laser colours, one bit per diode
	localparam logic [RGB_W-1:0] RGB_OFF   = 3'b000;
	localparam logic [RGB_W-1:0] RGB_RED   = 3'b100;
	localparam logic [RGB_W-1:0] RGB_GREEN = 3'b010;
	localparam logic [RGB_W-1:0] RGB_BLUE  = 3'b001;

	////////////////////////////////////////////////////////////////////////////
	// DAC word: {channel, cfg[2:0], data[11:0]}, sent MSB first
	////////////////////////////////////////////////////////////////////////////
	localparam int         DAC_WORD_W = 16;
	localparam logic [2:0] DAC_CFG    = 3'b001;
	localparam logic       CH_X       = 1'b0;
	localparam logic       CH_Y       = 1'b1;

endpackage
